/* filelist.f */
hw/debug_pkg.sv
hw/display_pkg.sv
hw/key_sync.sv
hw/scan_reg_file.sv
hw/seg_decoder.sv
hw/digit_scanner.sv
hw/debug_scan_top.sv
sim/tb_debug_scan.sv

/* hw/debug_pkg.sv */
`default_nettype none

// types shared by the register scan side of the debug path
package debug_pkg;

    localparam int REG_ADDR_W = 5;          // 32 registers
    localparam int REG_DATA_W = 32;         // cpu word
    localparam int DISP_HALF_W = 16;        // four hex digits on the display

    // register index
    typedef logic [REG_ADDR_W - 1 : 0]  reg_addr_t;

    // full register value
    typedef logic [REG_DATA_W - 1 : 0]  reg_data_t;

    // one half of a register, as it appears on the display
    typedef logic [DISP_HALF_W - 1 : 0] disp_half_t;

endpackage : debug_pkg

`default_nettype wire

/* hw/debug_scan_top.sv */
`timescale 1ns/10ps
`default_nettype none

// board wrapper for the seven-segment register debug path
module debug_scan_top
    import debug_pkg::*, display_pkg::*;
#(
    parameter int       SCAN_DIV     = 50000,   // cycles per digit slot
    parameter bit       COMMON_ANODE = 1'b0     // display polarity
)
(
    input   logic               clk,        // clock
    input   logic               resetn,     // reset, active low
    // register write from the cpu side
    input   logic               wr_valid,   // write strobe
    input   reg_addr_t          wr_addr,    // write index
    input   reg_data_t          wr_data,    // write value
    // board keys
    input   logic   [3 : 0]     key,        // register select
    input   logic               half_key,   // half select
    // seven-segment display
    output  seg_t               seg,        // segment pattern
    output  dig_sel_t           dig         // digit enables, active low
);

    reg_addr_t          scan_addr;  // synchronized register index
    logic               half_sel;   // synchronized half select
    reg_data_t          scan_data;  // selected register value

    key_sync u_key_sync
    (
        .clk        ( clk           ),  // clock
        .resetn     ( resetn        ),  // reset
        .key        ( key           ),  // raw register keys
        .half_key   ( half_key      ),  // raw half key
        .scan_addr  ( scan_addr     ),  // register index
        .half_sel   ( half_sel      )   // half select
    );

    scan_reg_file u_scan_reg_file
    (
        .clk        ( clk           ),  // clock
        .resetn     ( resetn        ),  // reset
        .wr_valid   ( wr_valid      ),  // write strobe
        .wr_addr    ( wr_addr       ),  // write index
        .wr_data    ( wr_data       ),  // write value
        .scan_addr  ( scan_addr     ),  // scan index
        .scan_data  ( scan_data     )   // scan value
    );

    digit_scanner
    #(
        .SCAN_DIV       ( SCAN_DIV      ),
        .COMMON_ANODE   ( COMMON_ANODE  )
    )
    u_digit_scanner
    (
        .clk        ( clk           ),  // clock
        .resetn     ( resetn        ),  // reset
        .scan_data  ( scan_data     ),  // register value
        .half_sel   ( half_sel      ),  // half select
        .seg        ( seg           ),  // segment pattern
        .dig        ( dig           )   // digit enables
    );

endmodule : debug_scan_top

`default_nettype wire

/* hw/digit_scanner.sv */
`timescale 1ns/10ps
`default_nettype none

// four-digit multiplexed display driver
// each slot is one blank cycle followed by SCAN_DIV - 1 cycles of one digit
module digit_scanner
    import debug_pkg::*, display_pkg::*;
#(
    parameter int       SCAN_DIV     = 50000,   // cycles per digit slot
    parameter bit       COMMON_ANODE = 1'b0     // display polarity
)
(
    input   logic               clk,        // clock
    input   logic               resetn,     // reset, active low
    input   reg_data_t          scan_data,  // register value to show
    input   logic               half_sel,   // 1 shows bits 31:16
    output  seg_t               seg,        // registered segment pattern
    output  dig_sel_t           dig         // registered digit enables
);

    localparam int      CNT_W   = ( SCAN_DIV > 1 ) ? $clog2(SCAN_DIV) : 1;
    localparam seg_t    SEG_DARK = COMMON_ANODE ? ~SEG_OFF : SEG_OFF;

    scan_state_t        state;      // scanner FSM state
    logic   [CNT_W - 1 : 0] slot_cnt;   // cycle within the slot
    logic   [1 : 0]     dig_idx;    // current digit, 0 is rightmost
    disp_half_t         half;       // selected half of the register
    nibble_t            nibble;     // digit value for dig_idx
    seg_t               seg_dec;    // decoded pattern for nibble
    logic               slot_end;   // last cycle of the slot

    assign half     = half_sel ? scan_data[31 : 16] : scan_data[15 : 0];
    assign nibble   = half[dig_idx * 4 +: 4];
    assign slot_end = ( slot_cnt == CNT_W'(SCAN_DIV - 1) );

    seg_decoder
    #(
        .COMMON_ANODE   ( COMMON_ANODE  )
    )
    u_seg_decoder
    (
        .nibble         ( nibble        ),  // digit value
        .seg            ( seg_dec       )   // pattern with polarity
    );

    always_ff @(posedge clk, negedge resetn)
        if( !resetn )
        begin
            state    <= SCAN_IDLE;
            slot_cnt <= '0;
            dig_idx  <= '0;
            seg      <= SEG_DARK;
            dig      <= DIG_NONE;
        end
        else
        begin
            unique case( state )
                SCAN_IDLE   :
                begin
                    state    <= SCAN_BLANK;
                    slot_cnt <= '0;
                end
                SCAN_BLANK  :
                begin
                    state    <= SCAN_SHOW;
                    slot_cnt <= slot_cnt + 1'b1;
                    seg      <= seg_dec;    // nibble sampled here
                    dig      <= ~( dig_sel_t'(1) << dig_idx );
                end
                SCAN_SHOW   :
                begin
                    if( slot_end )
                    begin
                        state    <= SCAN_BLANK;
                        slot_cnt <= '0;
                        dig_idx  <= dig_idx + 1'b1;    // wraps after digit 3
                        seg      <= SEG_DARK;
                        dig      <= DIG_NONE;
                    end
                    else
                        slot_cnt <= slot_cnt + 1'b1;
                end
                default     : state <= SCAN_IDLE;
            endcase
        end

    // never two digits on at once
    a_dig_one_low : assert property (
        @(posedge clk) disable iff (!resetn)
        ( dig == DIG_NONE ) || $onehot(~dig)
    ) else $error("digit_scanner: more than one digit enabled");

    // the gap cycle keeps every digit off
    a_blank_dark : assert property (
        @(posedge clk) disable iff (!resetn)
        ( state == SCAN_BLANK ) |-> ( dig == DIG_NONE )
    ) else $error("digit_scanner: digit enabled during blanking");

endmodule : digit_scanner

`default_nettype wire

/* hw/display_pkg.sv */
`default_nettype none

// seven-segment display types and the scanner state encoding
package display_pkg;

    // one hex digit
    typedef logic [3 : 0] nibble_t;

    // segment pattern, one bit per segment
    //   bit 0 .. bit 6 : segments a .. g
    //   bit 7          : decimal point, never lit here
    // a 1 means lit before the output polarity is applied
    typedef logic [7 : 0] seg_t;

    // digit enables, active low, bit 0 is the rightmost digit
    typedef logic [3 : 0] dig_sel_t;

    // scanner FSM
    typedef enum logic [1 : 0]
    {
        SCAN_IDLE   = 2'b00,    // out of reset, nothing shown
        SCAN_BLANK  = 2'b01,    // gap between two digits
        SCAN_SHOW   = 2'b10     // one digit driven
    } scan_state_t;

    // every segment dark, polarity not yet applied
    localparam seg_t SEG_OFF = 8'h00;

    // all digit enables released
    localparam dig_sel_t DIG_NONE = 4'b1111;

endpackage : display_pkg

`default_nettype wire

/* hw/key_sync.sv */
`timescale 1ns/10ps
`default_nettype none

// board keys come from an asynchronous domain, so they go through two flops
module key_sync
    import debug_pkg::*;
(
    input   logic               clk,        // clock
    input   logic               resetn,     // reset, active low
    input   logic   [3 : 0]     key,        // register select keys
    input   logic               half_key,   // half select key
    output  reg_addr_t          scan_addr,  // synchronized register index
    output  logic               half_sel    // synchronized half select
);

    // key and half_key handled as one 5-bit bundle
    logic   [4 : 0]     sync_meta;  // first stage, may go metastable
    logic   [4 : 0]     sync_q;     // second stage, safe to use

    always_ff @(posedge clk, negedge resetn)
        if( !resetn )
        begin
            sync_meta <= '0;
            sync_q    <= '0;
        end
        else
        begin
            sync_meta <= { half_key, key };
            sync_q    <= sync_meta;
        end

    // bit 4 of the address is held low, as on the board
    assign scan_addr = { 1'b0, sync_q[3 : 0] };
    assign half_sel  = sync_q[4];

    // the index feeds a combinational read, an X here spreads to the display
    a_scan_addr_known : assert property (
        @(posedge clk) disable iff (!resetn)
        !$isunknown(scan_addr)
    ) else $error("key_sync: scan_addr unknown after reset");

endmodule : key_sync

`default_nettype wire

/* hw/scan_reg_file.sv */
`timescale 1ns/10ps
`default_nettype none

// stand-in for the cpu register file
// one write port, one combinational scan port, x0 reads as zero
module scan_reg_file
    import debug_pkg::*;
(
    input   logic               clk,        // clock
    input   logic               resetn,     // reset, active low
    input   logic               wr_valid,   // write strobe
    input   reg_addr_t          wr_addr,    // write index
    input   reg_data_t          wr_data,    // write value
    input   reg_addr_t          scan_addr,  // scan index
    output  reg_data_t          scan_data   // scan value
);

    // entry 0 has no storage
    reg_data_t          regs [1 : 31];

    logic               wr_en;      // write to a real entry

    assign wr_en = wr_valid && ( wr_addr != '0 );

    always_ff @(posedge clk, negedge resetn)
        if( !resetn )
        begin
            for( int i = 1; i < 32; i++ )
                regs[i] <= '0;
        end
        else if( wr_en )
        begin
            regs[wr_addr] <= wr_data;
        end

    // no read register, a write shows up right after its edge
    always_comb
    begin
        if( scan_addr == '0 )
            scan_data = '0;
        else
            scan_data = regs[scan_addr];
    end

    // x0 stays zero whatever was written to it earlier
    a_x0_reads_zero : assert property (
        @(posedge clk) disable iff (!resetn)
        ( scan_addr == '0 ) |-> ( scan_data == '0 )
    ) else $error("scan_reg_file: register 0 read back non-zero");

    // a write to x0 is dropped and leaves the other entries alone
    a_x0_write_dropped : assert property (
        @(posedge clk) disable iff (!resetn)
        ( wr_valid && ( wr_addr == '0 ) && ( scan_addr != '0 ) )
            |=> ( $stable(scan_addr) -> $stable(scan_data) )
    ) else $error("scan_reg_file: write to register 0 changed another entry");

endmodule : scan_reg_file

`default_nettype wire

/* hw/seg_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

// hex digit to seven-segment pattern
module seg_decoder
    import display_pkg::*;
#(
    parameter bit       COMMON_ANODE = 1'b0     // 1 inverts every segment bit
)
(
    input   nibble_t            nibble,     // hex digit
    output  seg_t               seg         // segment pattern, polarity applied
);

    seg_t               seg_raw;    // lit = 1, dp in bit 7

    always_comb
    begin
        unique case( nibble )
            4'h0    : seg_raw = 8'h3f;
            4'h1    : seg_raw = 8'h06;
            4'h2    : seg_raw = 8'h5b;
            4'h3    : seg_raw = 8'h4f;
            4'h4    : seg_raw = 8'h66;
            4'h5    : seg_raw = 8'h6d;
            4'h6    : seg_raw = 8'h7d;
            4'h7    : seg_raw = 8'h07;
            4'h8    : seg_raw = 8'h7f;
            4'h9    : seg_raw = 8'h6f;
            4'ha    : seg_raw = 8'h77;  // A
            4'hb    : seg_raw = 8'h7c;  // lower case b
            4'hc    : seg_raw = 8'h39;  // C
            4'hd    : seg_raw = 8'h5e;  // lower case d
            4'he    : seg_raw = 8'h79;  // E
            4'hf    : seg_raw = 8'h71;  // F
            default : seg_raw = SEG_OFF;
        endcase
    end

    // common anode boards sink current, so a lit segment is a 0
    assign seg = COMMON_ANODE ? ~seg_raw : seg_raw;

endmodule : seg_decoder

`default_nettype wire

/* sim/tb_debug_scan.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_debug_scan
    import debug_pkg::*, display_pkg::*;
();

    localparam int      SCAN_DIV       = 4;
    localparam bit      COMMON_ANODE   = 1'b0;
    localparam int      LAT_BOUND      = 2 + 4 * SCAN_DIV + 2;    // write or key to display
    localparam int      TIMEOUT_CYCLES = 6000;
    localparam int      DRIVE_DELAY    = 2;                       // ns after the rising edge
    localparam seg_t    SEG_DARK       = COMMON_ANODE ? ~SEG_OFF : SEG_OFF;

    logic               clk;
    logic               resetn;
    logic               wr_valid;
    reg_addr_t          wr_addr;
    reg_data_t          wr_data;
    logic   [3 : 0]     key;
    logic               half_key;
    seg_t               seg;
    dig_sel_t           dig;

    reg_data_t          model [32];     // written registers, entry 0 stays zero
    logic   [31 : 0]    rng_state;
    int                 cycle_cnt;
    seg_t               shown_seg [4];  // last pattern seen per digit
    logic   [3 : 0]     shown_valid;
    dig_sel_t           prev_dig;
    logic   [1 : 0]     last_idx;
    logic               seen_any;

    debug_scan_top
    #(
        .SCAN_DIV       ( SCAN_DIV      ),
        .COMMON_ANODE   ( COMMON_ANODE  )
    )
    u_dut
    (
        .clk        ( clk       ),
        .resetn     ( resetn    ),
        .wr_valid   ( wr_valid  ),
        .wr_addr    ( wr_addr   ),
        .wr_data    ( wr_data   ),
        .key        ( key       ),
        .half_key   ( half_key  ),
        .seg        ( seg       ),
        .dig        ( dig       )
    );

    always #10 clk = ~clk;

    // segments listed gfedcba, lit = 1
    function automatic seg_t seg_ref(input nibble_t n);
        logic   [6 : 0] lit;
        seg_t           raw;
        case( n )
            4'h0    : lit = 7'b0111111;
            4'h1    : lit = 7'b0000110;
            4'h2    : lit = 7'b1011011;
            4'h3    : lit = 7'b1001111;
            4'h4    : lit = 7'b1100110;
            4'h5    : lit = 7'b1101101;
            4'h6    : lit = 7'b1111101;
            4'h7    : lit = 7'b0000111;
            4'h8    : lit = 7'b1111111;
            4'h9    : lit = 7'b1101111;
            4'ha    : lit = 7'b1110111;
            4'hb    : lit = 7'b1111100;     // lower case
            4'hc    : lit = 7'b0111001;
            4'hd    : lit = 7'b1011110;     // lower case
            4'he    : lit = 7'b1111001;
            default : lit = 7'b1110001;     // F
        endcase
        raw = { 1'b0, lit };                // dp dark
        return COMMON_ANODE ? ~raw : raw;
    endfunction

    // reverse lookup through the reference table
    function automatic nibble_t seg_to_nibble(input seg_t s);
        nibble_t        n;
        n = 'x;
        for( int i = 0; i < 16; i++ )
            if( seg_ref(nibble_t'(i)) == s )
                n = nibble_t'(i);
        return n;
    endfunction

    function automatic logic [31 : 0] xorshift32(input logic [31 : 0] x);
        x = x ^ ( x << 13 );
        x = x ^ ( x >> 17 );
        x = x ^ ( x << 5 );
        return x;
    endfunction

    function automatic logic [1 : 0] dig_index(input dig_sel_t d);
        logic   [1 : 0] idx;
        idx = '0;
        for( int i = 0; i < 4; i++ )
            if( !d[i] )
                idx = 2'(i);
        return idx;
    endfunction

    // all enables high except the one for digit idx
    function automatic dig_sel_t dig_for_index(input logic [1 : 0] idx);
        dig_sel_t       d;
        d      = 4'b1111;
        d[idx] = 1'b0;
        return d;
    endfunction

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_seg(input string name, input seg_t exp, input seg_t act);
        if( act !== exp )
        begin
            $display("ERR %s: seg expected %h, actual %h", name, exp, act);
            stop_with_error("segment pattern mismatch");
        end
    endtask

    task automatic check_dig(input string name, input dig_sel_t exp, input dig_sel_t act);
        if( act !== exp )
        begin
            $display("ERR %s: dig expected %b, actual %b", name, exp, act);
            stop_with_error("digit enable mismatch");
        end
    endtask

    task automatic check_half(input string name, input disp_half_t exp, input disp_half_t act);
        if( act !== exp )
        begin
            $display("ERR %s: half expected %h, actual %h", name, exp, act);
            stop_with_error("displayed value mismatch");
        end
    endtask

    task automatic write_reg(input reg_addr_t a, input reg_data_t d);
        @(posedge clk);
        #DRIVE_DELAY;
        wr_valid = 1'b1;
        wr_addr  = a;
        wr_data  = d;
        @(posedge clk);
        #DRIVE_DELAY;
        wr_valid = 1'b0;
        if( a != '0 )
            model[a] = d;           // x0 writes vanish
    endtask

    task automatic select_keys(input logic [3 : 0] a, input logic h);
        @(posedge clk);
        #DRIVE_DELAY;
        key      = a;
        half_key = h;
    endtask

    // waits out the latency, then gathers one full scan of four digits
    task automatic read_display(input string name, input reg_addr_t a, input logic h);
        disp_half_t     exp_half;
        disp_half_t     got_half;
        exp_half = h ? model[a][31 : 16] : model[a][15 : 0];
        repeat( LAT_BOUND ) @(posedge clk);
        shown_valid = '0;
        while( shown_valid != 4'b1111 )
            @(posedge clk);
        for( int k = 0; k < 4; k++ )
        begin
            check_seg(name, seg_ref(exp_half[4 * k +: 4]), shown_seg[k]);
            got_half[4 * k +: 4] = seg_to_nibble(shown_seg[k]);
        end
        check_half(name, exp_half, got_half);
    endtask

    // scan shape monitor and digit capture
    always @(negedge clk)
        if( resetn )
        begin
            if( dig != DIG_NONE )
            begin
                if( !$onehot(~dig) )
                    stop_with_error("more than one digit was enabled at the same time");
                if( ( prev_dig != DIG_NONE ) && ( prev_dig != dig ) )
                    stop_with_error("digit changed without a blank cycle in between");
                if( prev_dig == DIG_NONE )
                begin
                    check_dig("scan order",
                              dig_for_index(seen_any ? last_idx + 2'd1 : 2'd0), dig);
                    last_idx = dig_index(dig);
                    seen_any = 1'b1;
                end
                shown_seg[dig_index(dig)] = seg;
                shown_valid[dig_index(dig)] = 1'b1;
            end
            prev_dig = dig;
        end

    always @(posedge clk)
    begin
        cycle_cnt++;
        if( cycle_cnt >= TIMEOUT_CYCLES )
            stop_with_error("run stalled, cycle limit reached before the tests finished");
    end

    initial
    begin
        clk         = 1'b0;
        resetn      = 1'b0;
        wr_valid    = 1'b0;
        wr_addr     = '0;
        wr_data     = '0;
        key         = '0;
        half_key    = 1'b0;
        rng_state   = 32'h85f7_eba0;
        cycle_cnt   = 0;
        shown_valid = '0;
        prev_dig    = DIG_NONE;
        last_idx    = '0;
        seen_any    = 1'b0;
        for( int i = 0; i < 32; i++ )
            model[i] = '0;

        repeat( 4 )
        begin
            @(negedge clk);
            check_dig("reset", DIG_NONE, dig);
            check_seg("reset", SEG_DARK, seg);
        end
        @(posedge clk);
        #DRIVE_DELAY;
        resetn = 1'b1;
        @(posedge clk);                     // first edge after release
        @(negedge clk);
        check_dig("reset release", DIG_NONE, dig);
        check_seg("reset release", SEG_DARK, seg);

        write_reg(5'd5, 32'h89ab_cdef);
        select_keys(4'd5, 1'b0);
        read_display("lower half", 5'd5, 1'b0);
        select_keys(4'd5, 1'b1);
        read_display("upper half", 5'd5, 1'b1);

        write_reg(5'd0, 32'hdead_beef);
        select_keys(4'd0, 1'b0);
        read_display("x0 lower", 5'd0, 1'b0);
        select_keys(4'd0, 1'b1);
        read_display("x0 upper", 5'd0, 1'b1);

        for( int n = 0; n < 20; n++ )
        begin
            rng_state = xorshift32(rng_state);
            write_reg(reg_addr_t'(( rng_state % 15 ) + 1), xorshift32(rng_state));
            rng_state = xorshift32(rng_state);
        end
        for( int a = 1; a < 16; a++ )
        begin
            select_keys(4'(a), 1'b0);
            read_display("random lower", reg_addr_t'(a), 1'b0);
            select_keys(4'(a), 1'b1);
            read_display("random upper", reg_addr_t'(a), 1'b1);
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule : tb_debug_scan

`default_nettype wire
